// File: lsu_frontend.f
lsu_pkg.sv
lsu_addr_decode.sv
lsu_bypass.sv
lsu_addr_check.sv
lsu_result.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

// File: Bender.yml
package:
  name: lsu_frontend

sources:
  - lsu_pkg.sv
  - lsu_addr_decode.sv
  - lsu_bypass.sv
  - lsu_addr_check.sv
  - lsu_result.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_properties.sv
      - tb_lsu.sv

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    localparam int unsigned SEED           = 70159;
    localparam int unsigned N_RANDOM       = 120;
    // directed requests stay under 40
    localparam int unsigned N_REQ          = N_RANDOM + 40;
    localparam int unsigned TIMEOUT_CYCLES = N_REQ * 20;

    typedef struct packed {
        logic [XLEN-1:0]          addr;
        logic [BE_WIDTH-1:0]      be;
        logic                     we;
        logic [XLEN-1:0]          wdata;
        logic                     fault;
        logic [CAUSE_WIDTH-1:0]   cause;
        logic [TRANS_ID_BITS-1:0] id;
    } exp_t;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     flush_i;
    logic                     lsu_valid_i;
    fu_e                      fu_i;
    lsu_op_e                  operator_i;
    logic [XLEN-1:0]          operand_a_i;
    logic [XLEN-1:0]          operand_b_i;
    logic [XLEN-1:0]          imm_i;
    logic [TRANS_ID_BITS-1:0] trans_id_i;
    logic                     lsu_ready_o;
    logic                     mem_req_o;
    logic                     mem_gnt_i;
    logic [XLEN-1:0]          mem_addr_o;
    logic [BE_WIDTH-1:0]      mem_be_o;
    logic                     mem_we_o;
    logic [XLEN-1:0]          mem_wdata_o;
    logic                     lsu_valid_o;
    logic [TRANS_ID_BITS-1:0] lsu_trans_id_o;
    logic                     lsu_ex_valid_o;
    logic [CAUSE_WIDTH-1:0]   lsu_ex_cause_o;
    logic [XLEN-1:0]          lsu_ex_tval_o;

    // completions in request order, and requests still owed to memory
    exp_t        exp_q[$];
    exp_t        mem_q[$];
    int unsigned n_sent;
    logic        gnt_random;

    lsu_top u_lsu_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // failure reporting
    // --------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int unsigned op_bytes(input lsu_op_e op);
        case (op)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    function automatic logic is_store(input lsu_op_e op);
        return (op == SD) || (op == SW) || (op == SH) || (op == SB);
    endfunction

    function automatic exp_t predict(input lsu_op_e op, input logic [63:0] a,
                                     input logic [63:0] imm, input logic [63:0] b,
                                     input logic [TRANS_ID_BITS-1:0] id);
        exp_t        e;
        int unsigned nb;
        logic [15:0] wide;
        logic        misal;
        logic        noncanon;
        logic        st;
        nb       = op_bytes(op);
        st       = is_store(op);
        e.addr   = a + imm;
        wide     = ((16'd1 << nb) - 16'd1) << e.addr[2:0];
        e.be     = (wide[15:8] != 8'd0) ? 8'd0 : wide[7:0];
        misal    = (e.addr & 64'(nb - 1)) != 64'd0;
        noncanon = e.addr[XLEN-1:VA_BITS-1] != {(XLEN-VA_BITS+1){e.addr[VA_BITS-1]}};
        e.we     = st;
        e.wdata  = b;
        e.id     = id;
        e.fault  = misal || noncanon;
        if (noncanon) begin
            e.cause = st ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
        end else if (misal) begin
            e.cause = st ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        end else begin
            e.cause = '0;
        end
        return e;
    endfunction

    // kind 0 aligned, 1 misaligned, 2 non-canonical and odd
    function automatic logic [63:0] pick_addr(input int unsigned nb, input int unsigned kind);
        logic [63:0] addr;
        addr = {$urandom, $urandom};
        addr[XLEN-1:VA_BITS-1] = {(XLEN-VA_BITS+1){addr[VA_BITS-1]}};
        addr = addr & ~64'(nb - 1);
        if (kind == 1 && nb > 1) begin
            addr = addr | 64'(1 + ($urandom % (nb - 1)));
        end else if (kind == 2) begin
            addr[XLEN-1] = ~addr[VA_BITS-1];
            addr[0]      = 1'b1;
        end
        return addr;
    endfunction

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        mem_gnt_i = gnt_random ? (($urandom % 3) != 0) : 1'b0;
    endtask

    task automatic send_req(input lsu_op_e op, input logic [63:0] addr);
        logic [11:0] r;
        logic [63:0] imm;
        logic [63:0] b;
        exp_t        e;
        r   = 12'($urandom);
        imm = {{52{r[11]}}, r};
        b   = {$urandom, $urandom};
        while (!lsu_ready_o) next_cycle();
        e = predict(op, addr - imm, imm, b, TRANS_ID_BITS'(n_sent));
        exp_q.push_back(e);
        if (!e.fault) mem_q.push_back(e);
        n_sent++;
        lsu_valid_i = 1'b1;
        fu_i        = is_store(op) ? FU_STORE : FU_LOAD;
        operator_i  = op;
        operand_a_i = addr - imm;
        operand_b_i = b;
        imm_i       = imm;
        trans_id_i  = e.id;
        next_cycle();
        lsu_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) next_cycle();
    endtask

    // --------------------------------------------------
    // compare process
    // --------------------------------------------------
    always @(negedge clk_i) begin : compare
        exp_t e;
        if (rst_ni) begin
            if (lsu_valid_o) begin
                if (exp_q.size() == 0) begin
                    fail_run("completion seen with no request outstanding");
                end else begin
                    e = exp_q.pop_front();
                    check_value("lsu_trans_id_o", lsu_trans_id_o, e.id);
                    check_value("lsu_ex_valid_o", lsu_ex_valid_o, e.fault);
                    if (e.fault) begin
                        check_value("lsu_ex_cause_o", lsu_ex_cause_o, e.cause);
                        check_value("lsu_ex_tval_o", lsu_ex_tval_o, e.addr);
                    end
                end
            end
            if (mem_req_o) begin
                if (mem_q.size() == 0) begin
                    fail_run("memory request raised for a request that should fault");
                end else begin
                    e = mem_q[0];
                    check_value("mem_addr_o", mem_addr_o, e.addr);
                    check_value("mem_be_o", mem_be_o, e.be);
                    check_value("mem_we_o", mem_we_o, e.we);
                    check_value("mem_wdata_o", mem_wdata_o, e.wdata);
                    if (mem_gnt_i) void'(mem_q.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        fail_run($sformatf("timeout after %0d cycles, requests still pending", TIMEOUT_CYCLES));
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : stimulus
        lsu_op_e     op;
        int unsigned kind;
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        lsu_valid_i = 1'b0;
        fu_i        = FU_NONE;
        operator_i  = LD;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        trans_id_i  = '0;
        mem_gnt_i   = 1'b0;
        gnt_random  = 1'b1;
        n_sent      = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_value("lsu_ready_o", lsu_ready_o, 1'b1);
        check_value("mem_req_o", mem_req_o, 1'b0);
        check_value("lsu_valid_o", lsu_valid_o, 1'b0);

        // aligned, misaligned, then non-canonical for every operator
        for (int i = 0; i < 11; i++) begin
            op = lsu_op_e'(i);
            send_req(op, pick_addr(op_bytes(op), 0));
        end
        for (int i = 0; i < 11; i++) begin
            op = lsu_op_e'(i);
            if (op_bytes(op) > 1) begin
                send_req(op, pick_addr(op_bytes(op), 1));
            end
        end
        for (int i = 0; i < 11; i++) begin
            op = lsu_op_e'(i);
            send_req(op, pick_addr(op_bytes(op), 2));
        end
        drain();

        // stall one request in the buffer, then flush it
        gnt_random = 1'b0;
        mem_gnt_i  = 1'b0;
        send_req(SD, pick_addr(8, 0));
        next_cycle();
        check_value("lsu_ready_o", lsu_ready_o, 1'b0);
        flush_i = 1'b1;
        exp_q.delete();
        mem_q.delete();
        next_cycle();
        flush_i    = 1'b0;
        gnt_random = 1'b1;
        check_value("lsu_ready_o", lsu_ready_o, 1'b1);
        repeat (3) next_cycle();

        // random mix with grant gaps
        repeat (N_RANDOM) begin
            op   = lsu_op_e'($urandom % 11);
            kind = $urandom % 4;
            send_req(op, pick_addr(op_bytes(op), (kind == 3) ? 2 : (kind == 2) ? 1 : 0));
            repeat ($urandom % 3) next_cycle();
        end
        drain();
        repeat (3) next_cycle();

        if (mem_q.size() != 0) begin
            fail_run($sformatf("%0d requests completed without a memory grant",
                               mem_q.size()));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties import lsu_pkg::*; (
    input logic                clk_i,
    input logic                rst_ni,
    input logic                flush_i,
    input logic                lsu_valid_i,
    input logic                lsu_ready_o,
    input logic                mem_req_o,
    input logic                mem_gnt_i,
    input logic [XLEN-1:0]     mem_addr_o,
    input logic [BE_WIDTH-1:0] mem_be_o,
    input logic                mem_we_o,
    input logic [XLEN-1:0]     mem_wdata_o,
    input logic                lsu_valid_o
);

    // caller only issues into an empty buffer
    valid_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_i |-> lsu_ready_o)
        else $error("lsu_valid_i high while lsu_ready_o low");

    // stalled request holds until granted or flushed
    mem_port_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o && !mem_gnt_i) |=> flush_i || (mem_req_o && $stable(mem_addr_o)
        && $stable(mem_be_o) && $stable(mem_we_o) && $stable(mem_wdata_o)))
        else $error("memory port changed while waiting for grant");

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> (!mem_req_o && !lsu_valid_o))
        else $error("mem_req_o or lsu_valid_o high during reset");

endmodule

bind lsu_top lsu_properties u_lsu_properties (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .lsu_valid_i (lsu_valid_i),
    .lsu_ready_o (lsu_ready_o),
    .mem_req_o   (mem_req_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_addr_o  (mem_addr_o),
    .mem_be_o    (mem_be_o),
    .mem_we_o    (mem_we_o),
    .mem_wdata_o (mem_wdata_o),
    .lsu_valid_o (lsu_valid_o)
);

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,

    input  logic                     lsu_valid_i,
    input  fu_e                      fu_i,
    input  lsu_op_e                  operator_i,
    input  logic [XLEN-1:0]          operand_a_i,
    input  logic [XLEN-1:0]          operand_b_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [TRANS_ID_BITS-1:0] trans_id_i,
    output logic                     lsu_ready_o,

    output logic                     mem_req_o,
    input  logic                     mem_gnt_i,
    output logic [XLEN-1:0]          mem_addr_o,
    output logic [BE_WIDTH-1:0]      mem_be_o,
    output logic                     mem_we_o,
    output logic [XLEN-1:0]          mem_wdata_o,

    output logic                     lsu_valid_o,
    output logic [TRANS_ID_BITS-1:0] lsu_trans_id_o,
    output logic                     lsu_ex_valid_o,
    output logic [CAUSE_WIDTH-1:0]   lsu_ex_cause_o,
    output logic [XLEN-1:0]          lsu_ex_tval_o
);

    // decoded request
    logic                     req_valid;
    logic [XLEN-1:0]          req_vaddr;
    logic [XLEN-1:0]          req_wdata;
    logic [BE_WIDTH-1:0]      req_be;
    size_e                    req_size;
    fu_e                      req_fu;
    lsu_op_e                  req_op;

    // head of the buffer
    logic                     head_valid;
    logic [XLEN-1:0]          head_vaddr;
    logic [XLEN-1:0]          head_wdata;
    logic [BE_WIDTH-1:0]      head_be;
    size_e                    head_size;
    fu_e                      head_fu;
    logic [TRANS_ID_BITS-1:0] head_trans_id;

    logic                     fault;
    logic [CAUSE_WIDTH-1:0]   fault_cause;
    logic [XLEN-1:0]          fault_tval;
    logic                     pop;

    lsu_addr_decode u_lsu_addr_decode (
        .lsu_valid_i (lsu_valid_i),
        .fu_i        (fu_i),
        .operator_i  (operator_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .imm_i       (imm_i),
        .req_valid_o (req_valid),
        .req_vaddr_o (req_vaddr),
        .req_wdata_o (req_wdata),
        .req_be_o    (req_be),
        .req_size_o  (req_size),
        .req_fu_o    (req_fu),
        .req_op_o    (req_op)
    );

    lsu_bypass u_lsu_bypass (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .req_valid_i     (req_valid),
        .req_vaddr_i     (req_vaddr),
        .req_wdata_i     (req_wdata),
        .req_be_i        (req_be),
        .req_size_i      (req_size),
        .req_fu_i        (req_fu),
        .req_op_i        (req_op),
        .req_trans_id_i  (trans_id_i),
        .pop_i           (pop),
        .head_valid_o    (head_valid),
        .head_vaddr_o    (head_vaddr),
        .head_wdata_o    (head_wdata),
        .head_be_o       (head_be),
        .head_size_o     (head_size),
        .head_fu_o       (head_fu),
        .head_op_o       (),
        .head_trans_id_o (head_trans_id),
        .ready_o         (lsu_ready_o)
    );

    lsu_addr_check u_lsu_addr_check (
        .head_valid_i  (head_valid),
        .head_vaddr_i  (head_vaddr),
        .head_size_i   (head_size),
        .head_fu_i     (head_fu),
        .fault_o       (fault),
        .fault_cause_o (fault_cause),
        .fault_tval_o  (fault_tval)
    );

    lsu_result u_lsu_result (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mem_gnt_i       (mem_gnt_i),
        .head_valid_i    (head_valid),
        .head_vaddr_i    (head_vaddr),
        .head_wdata_i    (head_wdata),
        .head_be_i       (head_be),
        .head_fu_i       (head_fu),
        .head_trans_id_i (head_trans_id),
        .fault_i         (fault),
        .fault_cause_i   (fault_cause),
        .fault_tval_i    (fault_tval),
        .pop_o           (pop),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_be_o        (mem_be_o),
        .mem_we_o        (mem_we_o),
        .mem_wdata_o     (mem_wdata_o),
        .lsu_valid_o     (lsu_valid_o),
        .lsu_trans_id_o  (lsu_trans_id_o),
        .lsu_ex_valid_o  (lsu_ex_valid_o),
        .lsu_ex_cause_o  (lsu_ex_cause_o),
        .lsu_ex_tval_o   (lsu_ex_tval_o)
    );

endmodule

// File: lsu_result.sv
`timescale 1ns/1ps

module lsu_result import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mem_gnt_i,

    input  logic                     head_valid_i,
    input  logic [XLEN-1:0]          head_vaddr_i,
    input  logic [XLEN-1:0]          head_wdata_i,
    input  logic [BE_WIDTH-1:0]      head_be_i,
    input  fu_e                      head_fu_i,
    input  logic [TRANS_ID_BITS-1:0] head_trans_id_i,
    input  logic                     fault_i,
    input  logic [CAUSE_WIDTH-1:0]   fault_cause_i,
    input  logic [XLEN-1:0]          fault_tval_i,

    output logic                     pop_o,
    output logic                     mem_req_o,
    output logic [XLEN-1:0]          mem_addr_o,
    output logic [BE_WIDTH-1:0]      mem_be_o,
    output logic                     mem_we_o,
    output logic [XLEN-1:0]          mem_wdata_o,

    output logic                     lsu_valid_o,
    output logic [TRANS_ID_BITS-1:0] lsu_trans_id_o,
    output logic                     lsu_ex_valid_o,
    output logic [CAUSE_WIDTH-1:0]   lsu_ex_cause_o,
    output logic [XLEN-1:0]          lsu_ex_tval_o
);

    // --------------------------------------------------
    // memory port, straight from the head
    // --------------------------------------------------
    assign mem_req_o   = head_valid_i && !fault_i && !flush_i;
    assign mem_addr_o  = head_vaddr_i;
    assign mem_be_o    = head_be_i;
    assign mem_we_o    = (head_fu_i == FU_STORE);
    assign mem_wdata_o = head_wdata_i;

    // faults retire at once, others wait for the grant
    assign pop_o = head_valid_i && (fault_i || (mem_req_o && mem_gnt_i));

    // --------------------------------------------------
    // completion
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lsu_valid_o    <= 1'b0;
            lsu_ex_valid_o <= 1'b0;
        end else begin
            lsu_valid_o    <= pop_o && !flush_i;
            lsu_ex_valid_o <= pop_o && !flush_i && fault_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            lsu_trans_id_o <= head_trans_id_i;
            lsu_ex_cause_o <= fault_cause_i;
            lsu_ex_tval_o  <= fault_tval_i;
        end
    end

endmodule

// File: lsu_addr_check.sv
`timescale 1ns/1ps

module lsu_addr_check import lsu_pkg::*; (
    input  logic                   head_valid_i,
    input  logic [XLEN-1:0]        head_vaddr_i,
    input  size_e                  head_size_i,
    input  fu_e                    head_fu_i,

    output logic                   fault_o,
    output logic [CAUSE_WIDTH-1:0] fault_cause_o,
    output logic [XLEN-1:0]        fault_tval_o
);

    logic misaligned;
    logic non_canonical;
    logic is_store;

    assign is_store = (head_fu_i == FU_STORE);

    // --------------------------------------------------
    // alignment
    // --------------------------------------------------
    always_comb begin : misaligned_detect
        case (head_size_i)
            SIZE_D:  misaligned = (head_vaddr_i[2:0] != 3'b000);
            SIZE_W:  misaligned = (head_vaddr_i[1:0] != 2'b00);
            SIZE_H:  misaligned = head_vaddr_i[0];
            // bytes are always aligned
            default: misaligned = 1'b0;
        endcase
    end

    // upper bits must all be copies of bit VA_BITS-1
    assign non_canonical = !((&head_vaddr_i[XLEN-1:VA_BITS-1]) ||
                             !(|head_vaddr_i[XLEN-1:VA_BITS-1]));

    // page fault wins over misalignment
    always_comb begin : cause_select
        fault_cause_o = '0;
        if (non_canonical) begin
            fault_cause_o = is_store ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
        end else if (misaligned) begin
            fault_cause_o = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        end
    end

    assign fault_o      = head_valid_i && (misaligned || non_canonical);
    assign fault_tval_o = head_vaddr_i;

endmodule

// File: lsu_bypass.sv
`timescale 1ns/1ps

module lsu_bypass import lsu_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,

    input  logic                     req_valid_i,
    input  logic [XLEN-1:0]          req_vaddr_i,
    input  logic [XLEN-1:0]          req_wdata_i,
    input  logic [BE_WIDTH-1:0]      req_be_i,
    input  size_e                    req_size_i,
    input  fu_e                      req_fu_i,
    input  lsu_op_e                  req_op_i,
    input  logic [TRANS_ID_BITS-1:0] req_trans_id_i,
    input  logic                     pop_i,

    output logic                     head_valid_o,
    output logic [XLEN-1:0]          head_vaddr_o,
    output logic [XLEN-1:0]          head_wdata_o,
    output logic [BE_WIDTH-1:0]      head_be_o,
    output size_e                    head_size_o,
    output fu_e                      head_fu_o,
    output lsu_op_e                  head_op_o,
    output logic [TRANS_ID_BITS-1:0] head_trans_id_o,
    output logic                     ready_o
);

    // storage, one slot per entry
    logic [XLEN-1:0]          mem_vaddr_q    [2];
    logic [XLEN-1:0]          mem_wdata_q    [2];
    logic [BE_WIDTH-1:0]      mem_be_q       [2];
    size_e                    mem_size_q     [2];
    fu_e                      mem_fu_q       [2];
    lsu_op_e                  mem_op_q       [2];
    logic [TRANS_ID_BITS-1:0] mem_trans_id_q [2];

    logic [1:0] valid_n, valid_q;
    logic       rd_ptr_n, rd_ptr_q;
    logic       wr_ptr_n, wr_ptr_q;
    logic [1:0] cnt_n, cnt_q;
    logic       empty;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    // --------------------------------------------------
    // pointer and counter update
    // --------------------------------------------------
    always_comb begin : next_state
        valid_n  = valid_q;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        if (req_valid_i) begin
            valid_n[wr_ptr_q] = 1'b1;
            wr_ptr_n          = wr_ptr_q + 1'b1;
            cnt_n             = cnt_n + 2'd1;
        end

        // head leaves, slot is free again
        if (pop_i) begin
            valid_n[rd_ptr_q] = 1'b0;
            rd_ptr_n          = rd_ptr_q + 1'b1;
            cnt_n             = cnt_n - 2'd1;
        end

        if (flush_i) begin
            valid_n  = '0;
            rd_ptr_n = 1'b0;
            wr_ptr_n = 1'b0;
            cnt_n    = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            valid_q  <= valid_n;
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            mem_vaddr_q[wr_ptr_q]    <= req_vaddr_i;
            mem_wdata_q[wr_ptr_q]    <= req_wdata_i;
            mem_be_q[wr_ptr_q]       <= req_be_i;
            mem_size_q[wr_ptr_q]     <= req_size_i;
            mem_fu_q[wr_ptr_q]       <= req_fu_i;
            mem_op_q[wr_ptr_q]       <= req_op_i;
            mem_trans_id_q[wr_ptr_q] <= req_trans_id_i;
        end
    end

    // --------------------------------------------------
    // head selection
    // --------------------------------------------------
    // empty buffer passes the new request straight through
    always_comb begin : head_select
        if (empty) begin
            head_valid_o    = req_valid_i;
            head_vaddr_o    = req_vaddr_i;
            head_wdata_o    = req_wdata_i;
            head_be_o       = req_be_i;
            head_size_o     = req_size_i;
            head_fu_o       = req_fu_i;
            head_op_o       = req_op_i;
            head_trans_id_o = req_trans_id_i;
        end else begin
            head_valid_o    = valid_q[rd_ptr_q];
            head_vaddr_o    = mem_vaddr_q[rd_ptr_q];
            head_wdata_o    = mem_wdata_q[rd_ptr_q];
            head_be_o       = mem_be_q[rd_ptr_q];
            head_size_o     = mem_size_q[rd_ptr_q];
            head_fu_o       = mem_fu_q[rd_ptr_q];
            head_op_o       = mem_op_q[rd_ptr_q];
            head_trans_id_o = mem_trans_id_q[rd_ptr_q];
        end
    end

endmodule

// File: lsu_addr_decode.sv
`timescale 1ns/1ps

module lsu_addr_decode import lsu_pkg::*; (
    input  logic                lsu_valid_i,
    input  fu_e                 fu_i,
    input  lsu_op_e             operator_i,
    input  logic [XLEN-1:0]     operand_a_i,
    input  logic [XLEN-1:0]     operand_b_i,
    input  logic [XLEN-1:0]     imm_i,

    output logic                req_valid_o,
    output logic [XLEN-1:0]     req_vaddr_o,
    output logic [XLEN-1:0]     req_wdata_o,
    output logic [BE_WIDTH-1:0] req_be_o,
    output size_e               req_size_o,
    output fu_e                 req_fu_o,
    output lsu_op_e             req_op_o
);

    logic [XLEN-1:0]       vaddr;
    size_e                 size;
    logic [BE_WIDTH-1:0]   size_mask;
    // wide enough to see bytes shifted past byte 7
    logic [2*BE_WIDTH-2:0] be_wide;

    // --------------------------------------------------
    // address generation
    // --------------------------------------------------
    assign vaddr = $unsigned($signed(imm_i) + $signed(operand_a_i));

    // operator to access size
    always_comb begin : size_decode
        case (operator_i)
            LD, SD:       size = SIZE_D;
            LW, LWU, SW:  size = SIZE_W;
            LH, LHU, SH:  size = SIZE_H;
            default:      size = SIZE_B;
        endcase
    end

    // --------------------------------------------------
    // byte enable
    // --------------------------------------------------
    always_comb begin : size_to_mask
        case (size)
            SIZE_D:  size_mask = 8'b1111_1111;
            SIZE_W:  size_mask = 8'b0000_1111;
            SIZE_H:  size_mask = 8'b0000_0011;
            default: size_mask = 8'b0000_0001;
        endcase
    end

    assign be_wide = {{(BE_WIDTH-1){1'b0}}, size_mask} << vaddr[2:0];

    // access crossing the 8-byte line gets no byte enable
    assign req_be_o = (|be_wide[2*BE_WIDTH-2:BE_WIDTH]) ? '0 : be_wide[BE_WIDTH-1:0];

    assign req_valid_o = lsu_valid_i;
    assign req_vaddr_o = vaddr;
    assign req_wdata_o = operand_b_i;
    assign req_size_o  = size;
    assign req_fu_o    = fu_i;
    assign req_op_o    = operator_i;

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int unsigned XLEN          = 64;
    localparam int unsigned BE_WIDTH      = 8;
    localparam int unsigned TRANS_ID_BITS = 3;
    // sv39, bits 63 down to VA_BITS-1 must match
    localparam int unsigned VA_BITS       = 39;
    localparam int unsigned CAUSE_WIDTH   = 64;

    // --------------------------------------------------
    // exception cause codes
    // --------------------------------------------------
    localparam logic [CAUSE_WIDTH-1:0] CAUSE_LD_MISALIGNED = 64'd4;
    localparam logic [CAUSE_WIDTH-1:0] CAUSE_ST_MISALIGNED = 64'd6;
    localparam logic [CAUSE_WIDTH-1:0] CAUSE_LD_PAGE_FAULT = 64'd13;
    localparam logic [CAUSE_WIDTH-1:0] CAUSE_ST_PAGE_FAULT = 64'd15;

    // functional unit of the issued instruction
    typedef enum logic [1:0] {
        FU_NONE,
        FU_LOAD,
        FU_STORE
    } fu_e;

    // load and store operators
    typedef enum logic [3:0] {
        LD, LW, LWU, LH, LHU, LB, LBU,
        SD, SW, SH, SB
    } lsu_op_e;

    // access size
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } size_e;

endpackage
